// ==== Bender.yml ====
package:
  name: sfm_acc

sources:
  - files:
      - common/sfm_pkg.sv
      - design/sfm_tagger.sv
      - design/sfm_fifo.sv
      - accumulator/sfm_acc_ring.sv
      - design/sfm_acc_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_sfm_acc.sv

// ==== accumulator/sfm_acc_ring.sv ====
// **************************************************
// Softmax accumulator ring
// Circulates tagged partial sums through a
// pipelined add/multiply and reduces them
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module sfm_acc_ring #(
    parameter int unsigned NUM_STAGES = 3
) (
    input  wire logic                       clk_i,
    input  wire logic                       rst_ni,
    input  wire logic                       clear_i,
    input  wire logic                       reduce_i,
    input  wire sfm_pkg::addend_t           addend_i,
    input  wire logic                       addend_empty_i,
    output logic                            addend_pop_o,
    input  wire sfm_pkg::factor_t           factor_i,
    input  wire logic                       factor_empty_i,
    output logic                            factor_pop_o,
    output logic                            busy_o,
    output logic                            valid_o,
    output logic [sfm_pkg::ACC_W-1:0]       acc_o
);

    import sfm_pkg::*;

    localparam int unsigned CNT_W = $clog2(NUM_STAGES + 1);

    typedef struct packed {
        logic [ACC_W-1:0] value;
        logic [TAG_W-1:0] tag;
    } lane_t;

    typedef enum logic [1:0] {
        IDLE,
        DRAIN,
        SUM
    } state_e;

    lane_t            ring_q [NUM_STAGES];
    lane_t            exit_lane;
    lane_t            lane_d;
    logic             addend_match;
    logic             factor_match;
    logic [CNT_W-1:0] uses_q;
    logic [CNT_W-1:0] sum_cnt_q;
    logic [ACC_W-1:0] sum_q;
    logic             valid_q;
    state_e           state_q;

    assign exit_lane = ring_q[NUM_STAGES-1];

    // Addend has priority over a factor of the same tag
    assign addend_match = ~addend_empty_i & (addend_i.tag == exit_lane.tag);
    assign factor_match = ~addend_match & ~factor_empty_i & (factor_i.tag == exit_lane.tag);

    always_comb begin
        lane_d = exit_lane;
        if (addend_match) begin
            lane_d.value = exit_lane.value + ACC_W'(addend_i.value);
        end else if (factor_match) begin
            lane_d.value = exit_lane.value * ACC_W'(factor_i.value);
            lane_d.tag   = exit_lane.tag + 1'b1;
        end
    end

    assign addend_pop_o = addend_match;
    assign factor_pop_o = factor_match & (uses_q == CNT_W'(NUM_STAGES - 1));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < NUM_STAGES; i++) begin
                ring_q[i] <= '0;
            end
            uses_q <= '0;
        end else if (clear_i) begin
            for (int i = 0; i < NUM_STAGES; i++) begin
                ring_q[i] <= '0;
            end
            uses_q <= '0;
        end else begin
            ring_q[0] <= lane_d;
            for (int i = 1; i < NUM_STAGES; i++) begin
                ring_q[i] <= ring_q[i-1];
            end
            if (factor_pop_o) begin
                uses_q <= '0;
            end else if (factor_match) begin
                uses_q <= uses_q + 1'b1;
            end
        end
    end

    // Reduction control
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= IDLE;
            sum_cnt_q <= '0;
            sum_q     <= '0;
            valid_q   <= 1'b0;
        end else if (clear_i) begin
            state_q   <= IDLE;
            sum_cnt_q <= '0;
            sum_q     <= '0;
            valid_q   <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (reduce_i) begin
                        state_q <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (addend_empty_i && factor_empty_i) begin
                        state_q   <= SUM;
                        sum_cnt_q <= '0;
                        sum_q     <= '0;
                    end
                end
                SUM: begin
                    // One full revolution visits every lane once
                    sum_q     <= sum_q + exit_lane.value;
                    sum_cnt_q <= sum_cnt_q + 1'b1;
                    if (sum_cnt_q == CNT_W'(NUM_STAGES - 1)) begin
                        state_q <= IDLE;
                        valid_q <= 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign busy_o  = (state_q != IDLE);
    assign valid_o = valid_q;
    assign acc_o   = sum_q;

    // A partly used factor stays at the FIFO head
    a_uses_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
        uses_q != '0 |-> !factor_empty_i);
    // No item slips in while the lanes are summed
    a_sum_drained : assert property (@(posedge clk_i) disable iff (!rst_ni)
        state_q == SUM |-> addend_empty_i && factor_empty_i);

endmodule

`default_nettype wire

// ==== all.f ====
common/sfm_pkg.sv
design/sfm_tagger.sv
design/sfm_fifo.sv
accumulator/sfm_acc_ring.sv
design/sfm_acc_top.sv
verif/tb_clk_gen.sv
verif/tb_sfm_acc.sv

// ==== common/sfm_pkg.sv ====
// **************************************************
// Softmax accumulator shared definitions
// Datapath widths and tagged item structs
// **************************************************

`default_nettype none

package sfm_pkg;

    // Accumulator, addend and factor widths
    localparam int unsigned ACC_W = 32;
    localparam int unsigned ADD_W = 16;
    localparam int unsigned MUL_W = 16;

    // Tags wrap, only compared for equality
    localparam int unsigned TAG_W = 4;

    typedef struct packed {
        logic [ADD_W-1:0] value;
        logic [TAG_W-1:0] tag;
    } addend_t;

    typedef struct packed {
        logic [MUL_W-1:0] value;
        logic [TAG_W-1:0] tag;
    } factor_t;

endpackage

`default_nettype wire

// ==== design/sfm_acc_top.sv ====
// **************************************************
// Softmax accumulation datapath top level
// Tagger, addend and factor FIFOs, accumulator ring
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module sfm_acc_top #(
    parameter int unsigned NUM_STAGES   = 3,
    parameter int unsigned ADDEND_DEPTH = 12,
    parameter int unsigned FACTOR_DEPTH = 4
) (
    input  wire logic                        clk_i,
    input  wire logic                        rst_ni,
    input  wire logic                        clear_i,
    input  wire logic                        add_valid_i,
    input  wire logic [sfm_pkg::ADD_W-1:0]   add_i,
    input  wire logic                        mul_valid_i,
    input  wire logic [sfm_pkg::MUL_W-1:0]   mul_i,
    input  wire logic                        reduce_i,
    output logic                             ready_o,
    output logic                             valid_o,
    output logic [sfm_pkg::ACC_W-1:0]        acc_o
);

    import sfm_pkg::*;

    addend_t addend_push_data;
    addend_t addend_head;
    logic    addend_push;
    logic    addend_pop;
    logic    addend_full;
    logic    addend_empty;

    factor_t factor_push_data;
    factor_t factor_head;
    logic    factor_push;
    logic    factor_pop;
    logic    factor_full;
    logic    factor_empty;

    logic    busy;

    sfm_tagger i_tagger (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .clear_i       (clear_i),
        .add_valid_i   (add_valid_i),
        .add_i         (add_i),
        .mul_valid_i   (mul_valid_i),
        .mul_i         (mul_i),
        .addend_full_i (addend_full),
        .factor_full_i (factor_full),
        .busy_i        (busy),
        .ready_o       (ready_o),
        .addend_push_o (addend_push),
        .addend_o      (addend_push_data),
        .factor_push_o (factor_push),
        .factor_o      (factor_push_data)
    );

    sfm_fifo #(
        .DEPTH  (ADDEND_DEPTH),
        .item_t (addend_t)
    ) i_addend_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (clear_i),
        .push_i  (addend_push),
        .data_i  (addend_push_data),
        .pop_i   (addend_pop),
        .data_o  (addend_head),
        .full_o  (addend_full),
        .empty_o (addend_empty)
    );

    sfm_fifo #(
        .DEPTH  (FACTOR_DEPTH),
        .item_t (factor_t)
    ) i_factor_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (clear_i),
        .push_i  (factor_push),
        .data_i  (factor_push_data),
        .pop_i   (factor_pop),
        .data_o  (factor_head),
        .full_o  (factor_full),
        .empty_o (factor_empty)
    );

    sfm_acc_ring #(
        .NUM_STAGES (NUM_STAGES)
    ) i_acc_ring (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .clear_i        (clear_i),
        .reduce_i       (reduce_i),
        .addend_i       (addend_head),
        .addend_empty_i (addend_empty),
        .addend_pop_o   (addend_pop),
        .factor_i       (factor_head),
        .factor_empty_i (factor_empty),
        .factor_pop_o   (factor_pop),
        .busy_o         (busy),
        .valid_o        (valid_o),
        .acc_o          (acc_o)
    );

endmodule

`default_nettype wire

// ==== design/sfm_fifo.sv ====
// **************************************************
// Tagged item FIFO
// Circular buffer with flush, no fall-through
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module sfm_fifo #(
    parameter int unsigned DEPTH  = 4,
    parameter type         item_t = logic
) (
    input  wire logic  clk_i,
    input  wire logic  rst_ni,
    input  wire logic  flush_i,
    input  wire logic  push_i,
    input  wire item_t data_i,
    input  wire logic  pop_i,
    output item_t      data_o,
    output logic       full_o,
    output logic       empty_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    item_t            mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(push_i) - CNT_W'(pop_i);
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    assign data_o  = mem_q[rd_ptr_q];
    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);

    a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i && !flush_i |-> !full_o);
    a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i && !flush_i |-> !empty_o);

endmodule

`default_nettype wire

// ==== design/sfm_tagger.sv ====
// **************************************************
// Softmax input tagger
// Tags addends and factors, generates ready_o
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module sfm_tagger (
    input  wire logic                        clk_i,
    input  wire logic                        rst_ni,
    input  wire logic                        clear_i,
    input  wire logic                        add_valid_i,
    input  wire logic [sfm_pkg::ADD_W-1:0]   add_i,
    input  wire logic                        mul_valid_i,
    input  wire logic [sfm_pkg::MUL_W-1:0]   mul_i,
    input  wire logic                        addend_full_i,
    input  wire logic                        factor_full_i,
    input  wire logic                        busy_i,
    output logic                             ready_o,
    output logic                             addend_push_o,
    output sfm_pkg::addend_t                 addend_o,
    output logic                             factor_push_o,
    output sfm_pkg::factor_t                 factor_o
);

    import sfm_pkg::*;

    logic [TAG_W-1:0] tag_q;
    logic             init_q;

    // Low for one cycle after reset while the ring initializes
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            init_q <= 1'b0;
            tag_q  <= '0;
        end else if (clear_i) begin
            init_q <= 1'b0;
            tag_q  <= '0;
        end else begin
            init_q <= 1'b1;
            if (factor_push_o) begin
                tag_q <= tag_q + 1'b1;
            end
        end
    end

    assign ready_o = init_q & ~addend_full_i & ~factor_full_i & ~busy_i;

    assign addend_push_o = add_valid_i & ready_o;
    assign factor_push_o = mul_valid_i & ready_o;

    // Addend accepted with a factor is not scaled by it
    assign addend_o.value = add_i;
    assign addend_o.tag   = tag_q + TAG_W'(factor_push_o);

    assign factor_o.value = mul_i;
    assign factor_o.tag   = tag_q;

endmodule

`default_nettype wire

// ==== verif/sfm_acc_tests.txt ====
# Softmax accumulator test vectors, values in hex
# T name starts a test | A addend | M factor | B addend factor in one cycle
# W idle cycles (decimal) | C clear | P expect ready_o dropped | R expected acc_o
T addends_only
A 0001
A 0002
A 0003
A ffff
R 00010005
T interleaved
C
A 0002
M 0003
W 3
A 0005
M 0007
A 000b
R 00000058
T same_cycle
C
B 0006 0004
A 0004
B 0003 0005
A 0002
M 0002
R 0000006e
T factors_first
C
M 0009
M 0002
A 0007
R 00000007
T backpressure
C
A 0001
M 0002
M 0002
M 0002
M 0002
M 0002
M 0002
A 0003
M 0002
P
R 00000086
T clear_discard
C
A 0100
M 0010
A 0020
C
A 0005
M 0003
A 0004
R 00000013
T product_wrap
C
A ffff
M ffff
A 1234
M ffff
R 1236edcb

// ==== verif/tb_clk_gen.sv ====
// **************************************************
// Testbench clock and reset generator
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int unsigned PERIOD       = 10,
    parameter int unsigned RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Release away from the clock edge
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_no = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/tb_sfm_acc.sv ====
// **************************************************
// Testbench for the softmax accumulation datapath
// Replays the test file and checks reduce results
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module tb_sfm_acc;

    import sfm_pkg::*;

    localparam int unsigned CLK_PERIOD = 10;

    logic             clk;
    logic             rst_n;
    logic             clear;
    logic             add_valid;
    logic [ADD_W-1:0] add_data;
    logic             mul_valid;
    logic [MUL_W-1:0] mul_data;
    logic             reduce;
    logic             ready;
    logic             valid;
    logic [ACC_W-1:0] acc;

    string lines[$];
    string test_name;
    int    num_errors = 0;
    int    errors_at_start = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    reduce_count = 0;
    int    valid_count = 0;
    bit    test_open = 1'b0;
    bit    stall_seen = 1'b0;
    bit    lines_loaded = 1'b0;

    tb_clk_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (10)
    ) i_clk_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    sfm_acc_top #(
        .NUM_STAGES   (3),
        .ADDEND_DEPTH (12),
        .FACTOR_DEPTH (4)
    ) i_dut (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .clear_i     (clear),
        .add_valid_i (add_valid),
        .add_i       (add_data),
        .mul_valid_i (mul_valid),
        .mul_i       (mul_data),
        .reduce_i    (reduce),
        .ready_o     (ready),
        .valid_o     (valid),
        .acc_o       (acc)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error %s: got 0x%08h, expected 0x%08h", name, got, exp);
            num_errors++;
        end
    endtask

    function automatic string trim_line(input string s);
        string t;
        t = s;
        while (t.len() > 0 && (t.getc(t.len() - 1) == "\n" ||
               t.getc(t.len() - 1) == "\r" || t.getc(t.len() - 1) == " ")) begin
            t = t.substr(0, t.len() - 2);
        end
        return t;
    endfunction

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = num_errors;
        stall_seen      = 1'b0;
        test_open       = 1'b1;
    endtask

    task automatic end_test();
        if (test_open) begin
            tests_run++;
            if (num_errors == errors_at_start) begin
                $display("test %0d %s: pass", tests_run, test_name);
            end else begin
                tests_failed++;
                $display("test %0d %s: fail", tests_run, test_name);
            end
            test_open = 1'b0;
        end
    endtask

    // Hold the item until ready_o is seen high
    task automatic drive_item(input logic a_v, input logic [ADD_W-1:0] a,
                              input logic m_v, input logic [MUL_W-1:0] m);
        logic taken;
        add_valid = a_v;
        add_data  = a;
        mul_valid = m_v;
        mul_data  = m;
        taken     = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = ready;
            if (!taken) begin
                stall_seen = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        add_valid = 1'b0;
        mul_valid = 1'b0;
    endtask

    task automatic wait_ready();
        while (!ready) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic pulse_clear();
        clear = 1'b1;
        @(posedge clk);
        #1;
        clear = 1'b0;
        wait_ready();
    endtask

    task automatic reduce_and_check(input logic [ACC_W-1:0] expected);
        wait_ready();
        reduce = 1'b1;
        reduce_count++;
        @(posedge clk);
        #1;
        reduce = 1'b0;
        do begin
            @(negedge clk);
        end while (!valid);
        check_value("acc_o", acc, expected);
        @(posedge clk);
        #1;
    endtask

    task automatic run_line(input string line);
        byte         cmd;
        string       rest;
        logic [31:0] v1;
        logic [31:0] v2;
        cmd  = line.getc(0);
        rest = line.substr(1, line.len() - 1);
        v1   = '0;
        v2   = '0;
        case (cmd)
            "T": begin
                end_test();
                start_test(line.substr(2, line.len() - 1));
            end
            "A": begin
                void'($sscanf(rest, "%h", v1));
                drive_item(1'b1, v1[ADD_W-1:0], 1'b0, '0);
            end
            "M": begin
                void'($sscanf(rest, "%h", v1));
                drive_item(1'b0, '0, 1'b1, v1[MUL_W-1:0]);
            end
            "B": begin
                void'($sscanf(rest, "%h %h", v1, v2));
                drive_item(1'b1, v1[ADD_W-1:0], 1'b1, v2[MUL_W-1:0]);
            end
            "W": begin
                void'($sscanf(rest, "%d", v1));
                repeat (v1) begin
                    @(posedge clk);
                    #1;
                end
            end
            "C": pulse_clear();
            "P": check_value("ready_o dropped", 32'(stall_seen), 32'd1);
            "R": begin
                void'($sscanf(rest, "%h", v1));
                reduce_and_check(v1);
            end
            default: begin
                $display("unknown command in test file: %s", line);
                num_errors++;
            end
        endcase
    endtask

    // Every high cycle of valid_o counts as one pulse
    always @(negedge clk) begin
        if (rst_n && valid) begin
            valid_count++;
        end
    end

    initial begin
        int    fd;
        string line;
        clear     = 1'b0;
        add_valid = 1'b0;
        add_data  = '0;
        mul_valid = 1'b0;
        mul_data  = '0;
        reduce    = 1'b0;
        fd = $fopen("verif/sfm_acc_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file verif/sfm_acc_tests.txt");
            num_errors++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0) begin
                    line = trim_line(line);
                    if (line.len() > 0 && line.getc(0) != "#") begin
                        lines.push_back(line);
                    end
                end
            end
            $fclose(fd);
            lines_loaded = 1'b1;

            start_test("reset");
            wait (rst_n === 1'b1);
            check_value("valid_o", 32'(valid), 32'd0);
            repeat (2) begin
                if (!ready) begin
                    @(posedge clk);
                    #1;
                end
            end
            check_value("ready_o", 32'(ready), 32'd1);

            foreach (lines[i]) begin
                run_line(lines[i]);
            end
            end_test();
            check_value("valid_o pulses", valid_count, reduce_count);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, num_errors);
        if (num_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        longint unsigned limit;
        wait (lines_loaded);
        limit = 200 * (lines.size() + 1);
        #(limit * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire
